// File: design/ti_mem_pkg.sv
// Shared types and memory-map constants for the CPU-side memory system.
// Every design file takes what it needs by scoped names.

`default_nettype none

package ti_mem_pkg;

  // ----------------------------------------
  // Bus and register widths
  // ----------------------------------------
  typedef logic [15:0] cpu_addr_t;  // CPU byte address
  typedef logic [15:0] cpu_data_t;  // CPU data word
  typedef logic [22:0] xaddr_t;     // External memory word address
  typedef logic [7:0]  bank_t;      // Cartridge bank number
  typedef logic [7:0]  sams_page_t; // SAMS page number
  typedef logic [15:0] win_reg_t;   // Upper part of the window address

  // Memory request sequencer
  typedef enum logic [1:0] {
    IDLE     = 2'd0,  // Waiting for a strobe
    WAIT_ACK = 2'd1,  // Request issued, memory busy
    DONE     = 2'd2   // Ready held until the strobes drop
  } seq_state_t;

  // ----------------------------------------
  // Region match values
  // ----------------------------------------
  localparam logic [2:0] ROM_HI3      = 3'b000;     // 0000..1FFF, bits 15:13
  localparam logic [2:0] SAMS_REG_HI3 = 3'b010;     // 4000..5FFF, bits 15:13
  localparam logic [2:0] CART_HI3     = 3'b011;     // 6000..7FFF, bits 15:13
  localparam logic [5:0] SCRATCH_HI6  = 6'b100000;  // 8000..83FF, bits 15:10
  localparam logic [7:0] WINDOW_HI8   = 8'h85;      // Paged window
  localparam logic [7:0] WINREG_HI8   = 8'h86;      // Window register
  localparam logic [7:0] SAMS_CRU_HI8 = 8'h1E;      // SAMS control bits in CRU space

  // Top bits of the external address for the paged regions
  localparam logic [2:0] CART_XBASE = 3'b001;   // Cartridge pages at 2M
  localparam logic [3:0] SAMS_XBASE = 4'b0001;  // SAMS pages at 1M

endpackage

`default_nettype wire

// File: design/cs_decode.sv
// Address decoder for the CPU memory map.
// Produces the chip select of every region, including the write protection
// of ROM and cartridge space. Purely combinational.

`timescale 1ns/1ps
`default_nettype none

module cs_decode (
  input  ti_mem_pkg::cpu_addr_t cpu_addr_i,
  input  wire                   cpu_wr_i,
  input  wire                   sams_en_i,      // From the SAMS CRU bit
  output logic                  xram_cs_o,      // Access goes to external memory
  output logic                  cart_cs_o,
  output logic                  window_cs_o,
  output logic                  winreg_cs_o,
  output logic                  sams_reg_cs_o,
  output logic                  sams_area_cs_o,
  output logic                  sams_cru_cs_o
);

  logic rom_cs;      // 0000..1FFF
  logic low32k_cs;   // 2000..3FFF
  logic scratch_cs;  // 8000..83FF
  logic high32k_cs;  // A000..FFFF

  // ----------------------------------------
  // Region match
  // ----------------------------------------
  assign rom_cs     = cpu_addr_i[15:13] == ti_mem_pkg::ROM_HI3;
  assign low32k_cs  = cpu_addr_i[15:13] == 3'b001;
  assign scratch_cs = cpu_addr_i[15:10] == ti_mem_pkg::SCRATCH_HI6;
  assign high32k_cs = (cpu_addr_i[15:13] == 3'b101) ||  // A000..BFFF
                      (cpu_addr_i[15:14] == 2'b11);     // C000..FFFF

  assign cart_cs_o     = cpu_addr_i[15:13] == ti_mem_pkg::CART_HI3;  // Reads and bank writes
  assign window_cs_o   = cpu_addr_i[15:8] == ti_mem_pkg::WINDOW_HI8;
  assign winreg_cs_o   = cpu_addr_i[15:8] == ti_mem_pkg::WINREG_HI8;
  assign sams_cru_cs_o = cpu_addr_i[15:8] == ti_mem_pkg::SAMS_CRU_HI8;

  // Page registers only show up while the unit is enabled
  assign sams_reg_cs_o = (cpu_addr_i[15:13] == ti_mem_pkg::SAMS_REG_HI3) && sams_en_i;

  // The 32K expansion RAM is the pageable area
  assign sams_area_cs_o = low32k_cs || high32k_cs;

  // ----------------------------------------
  // External memory select
  // ----------------------------------------
  // ROM and cartridge are read only so a write there never reaches memory
  assign xram_cs_o = (rom_cs && !cpu_wr_i)    ||
                     low32k_cs                ||
                     (cart_cs_o && !cpu_wr_i) ||
                     scratch_cs               ||
                     window_cs_o              ||
                     high32k_cs;

endmodule

`default_nettype wire

// File: design/bank_regs.sv
// Cartridge bank register and paged memory window register.
// Both load on the first cycle of a CPU write to their region.

`timescale 1ns/1ps
`default_nettype none

module bank_regs (
  input  wire                    clk,
  input  wire                    cpu_reset,
  input  ti_mem_pkg::cpu_addr_t  cpu_addr_i,
  input  ti_mem_pkg::cpu_data_t  cpu_data_i,
  input  wire                    wr_start_i,   // One cycle, start of a write
  input  wire                    cart_cs_i,    // 6000..7FFF
  input  wire                    winreg_cs_i,  // 86xx
  output ti_mem_pkg::bank_t      cart_bank_o,
  output ti_mem_pkg::win_reg_t   win_reg_o
);

  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      cart_bank_o <= '0;
      win_reg_o   <= '0;
    end else begin
      // Extended BASIC banking takes the page number from the address bus
      if (wr_start_i && cart_cs_i) begin
        cart_bank_o <= cpu_addr_i[8:1];
      end
      if (wr_start_i && winreg_cs_i) begin
        win_reg_o <= cpu_data_i;  // Top 16 bits of the window address
      end
    end
  end

endmodule

`default_nettype wire

// File: design/sams_pager.sv
// SAMS memory paging unit.
// CRU bit 1E00 shows the page registers at 4000..5FFF, CRU bit 1E02 turns
// the mapping on. With mapping on, bits 15:12 of a CPU address pick one of
// the 16 page registers; with it off the page is just those address bits.

`timescale 1ns/1ps
`default_nettype none

module sams_pager (
  input  wire                     clk,
  input  wire                     cpu_reset,
  input  ti_mem_pkg::cpu_addr_t   cpu_addr_i,
  input  ti_mem_pkg::cpu_data_t   cpu_data_i,
  input  wire                     wr_start_i,
  input  wire                     cru_clk_i,
  input  wire                     cru_bit_i,
  input  wire                     sams_cru_cs_i,  // CRU base 1E00
  input  wire                     sams_reg_cs_i,  // Page register area
  output logic                    sams_en_o,
  output ti_mem_pkg::sams_page_t  page_o,
  output ti_mem_pkg::cpu_data_t   reg_rdata_o
);

  logic                   last_cru_clk;
  logic                   cru_clk_rise;
  logic                   map_en;        // Translation active
  ti_mem_pkg::sams_page_t page_regs [16];
  ti_mem_pkg::sams_page_t reg_sel;       // Register addressed at 4000..401F

  assign cru_clk_rise = cru_clk_i && !last_cru_clk;

  // ----------------------------------------
  // CRU control bits
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      last_cru_clk <= 1'b0;
      sams_en_o    <= 1'b0;
      map_en       <= 1'b0;
    end else begin
      last_cru_clk <= cru_clk_i;
      if (cru_clk_rise && sams_cru_cs_i) begin
        if (cpu_addr_i[7:1] == 7'd0) begin
          sams_en_o <= cru_bit_i;  // 1E00
        end else if (cpu_addr_i[7:1] == 7'd1) begin
          map_en <= cru_bit_i;     // 1E02
        end
      end
    end
  end

  // ----------------------------------------
  // Page registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      for (int i = 0; i < 16; i++) begin
        page_regs[i] <= '0;
      end
    end else if (wr_start_i && sams_reg_cs_i) begin
      page_regs[cpu_addr_i[4:1]] <= cpu_data_i[15:8];  // Page number in the high byte
    end
  end

  assign reg_sel     = page_regs[cpu_addr_i[4:1]];
  assign reg_rdata_o = {reg_sel, reg_sel};  // Same byte on both halves

  // Lookup for the 4K block being accessed
  assign page_o = map_en ? page_regs[cpu_addr_i[15:12]]
                         : {4'b0000, cpu_addr_i[15:12]};

endmodule

`default_nettype wire

// File: design/xaddr_map.sv
// External address construction and CPU read-data selection.
// Maps each CPU word address into the 23-bit external memory space and
// picks the source of the data returned to the CPU.

`timescale 1ns/1ps
`default_nettype none

module xaddr_map (
  input  ti_mem_pkg::cpu_addr_t   cpu_addr_i,
  input  wire                     cart_cs_i,
  input  wire                     window_cs_i,
  input  wire                     sams_area_cs_i,
  input  wire                     winreg_cs_i,
  input  wire                     sams_reg_cs_i,
  input  wire                     xram_cs_i,
  input  ti_mem_pkg::bank_t       cart_bank_i,
  input  ti_mem_pkg::win_reg_t    win_reg_i,
  input  ti_mem_pkg::sams_page_t  sams_page_i,
  input  ti_mem_pkg::cpu_data_t   sams_rdata_i,
  input  ti_mem_pkg::cpu_data_t   mem_rdata_i,
  output ti_mem_pkg::xaddr_t      mem_addr_o,
  output ti_mem_pkg::cpu_data_t   cpu_data_o
);

  ti_mem_pkg::xaddr_t cart_xaddr;
  ti_mem_pkg::xaddr_t window_xaddr;
  ti_mem_pkg::xaddr_t sams_xaddr;
  ti_mem_pkg::xaddr_t plain_xaddr;

  // ----------------------------------------
  // Address candidates
  // ----------------------------------------
  assign cart_xaddr   = {ti_mem_pkg::CART_XBASE, cart_bank_i, cpu_addr_i[12:1]};  // 256 x 8K
  assign window_xaddr = {win_reg_i, cpu_addr_i[7:1]};       // 256-byte window anywhere
  assign sams_xaddr   = {ti_mem_pkg::SAMS_XBASE, sams_page_i, cpu_addr_i[11:1]};  // 4K pages
  assign plain_xaddr  = {8'h00, cpu_addr_i[15:1]};

  assign mem_addr_o = cart_cs_i      ? cart_xaddr   :
                      window_cs_i    ? window_xaddr :
                      sams_area_cs_i ? sams_xaddr   :
                                       plain_xaddr;

  // Read data with the registers taking priority
  assign cpu_data_o = winreg_cs_i   ? win_reg_i    :
                      sams_reg_cs_i ? sams_rdata_i :
                      xram_cs_i     ? mem_rdata_i  :
                                      '0;           // Unmapped or protected

endmodule

`default_nettype wire

// File: design/xmem_seq.sv
// Turns the level rd/wr strobes of the CPU into one-cycle memory requests
// and drives CPU ready. Ready latches until both strobes are low.

`timescale 1ns/1ps
`default_nettype none

module xmem_seq (
  input  wire   clk,
  input  wire   cpu_reset,
  input  wire   cpu_rd_i,
  input  wire   cpu_wr_i,
  input  wire   xram_cs_i,    // Target is external memory
  input  wire   mem_ack_i,
  output logic  mem_rd_rq_o,
  output logic  mem_wr_rq_o,
  output logic  wr_start_o,   // First cycle of a write, to the registers
  output logic  cpu_ready_o
);

  logic                   last_rd, last_wr;
  logic                   rd_start, access_start;
  ti_mem_pkg::seq_state_t state;

  assign rd_start     = cpu_rd_i && !last_rd;
  assign wr_start_o   = cpu_wr_i && !last_wr;
  assign access_start = rd_start || wr_start_o;

  assign mem_rd_rq_o = rd_start && xram_cs_i;
  assign mem_wr_rq_o = wr_start_o && xram_cs_i;

  always_ff @(posedge clk) begin
    if (cpu_reset) begin
      last_rd <= 1'b0;
      last_wr <= 1'b0;
      state   <= ti_mem_pkg::IDLE;
    end else begin
      last_rd <= cpu_rd_i;
      last_wr <= cpu_wr_i;
      case (state)
        ti_mem_pkg::IDLE: if (access_start) begin
          // Internal targets answer one cycle later
          state <= xram_cs_i ? ti_mem_pkg::WAIT_ACK : ti_mem_pkg::DONE;
        end
        ti_mem_pkg::WAIT_ACK: if (mem_ack_i) state <= ti_mem_pkg::DONE;
        ti_mem_pkg::DONE: if (!cpu_rd_i && !cpu_wr_i) state <= ti_mem_pkg::IDLE;
        default: state <= ti_mem_pkg::IDLE;
      endcase
    end
  end

  // Ready in the ack cycle itself, then held in DONE
  assign cpu_ready_o = (state == ti_mem_pkg::WAIT_ACK && mem_ack_i) ||
                       (state == ti_mem_pkg::DONE);

endmodule

`default_nettype wire

// File: design/ti_memsys.sv
// CPU-side memory system top level.
// Decodes the CPU bus, keeps the bank, window and SAMS registers, and turns
// each CPU access into at most one request on the external memory port.

`timescale 1ns/1ps
`default_nettype none

module ti_memsys (
  input  wire                    clk,
  input  wire                    cpu_reset,
  // CPU bus
  input  ti_mem_pkg::cpu_addr_t  cpu_addr_i,
  input  ti_mem_pkg::cpu_data_t  cpu_data_i,
  input  wire                    cpu_rd_i,
  input  wire                    cpu_wr_i,
  input  wire                    cru_clk_i,
  input  wire                    cru_bit_i,
  output ti_mem_pkg::cpu_data_t  cpu_data_o,
  output logic                   cpu_ready_o,
  // External memory port
  input  ti_mem_pkg::cpu_data_t  mem_rdata_i,
  input  wire                    mem_ack_i,
  output ti_mem_pkg::xaddr_t     mem_addr_o,
  output ti_mem_pkg::cpu_data_t  mem_wdata_o,
  output logic                   mem_rd_rq_o,
  output logic                   mem_wr_rq_o
);

  // Chip selects
  logic xram_cs, cart_cs, window_cs, winreg_cs;
  logic sams_reg_cs, sams_area_cs, sams_cru_cs;

  logic                   sams_en;     // SAMS registers visible at 4000
  logic                   wr_start;    // First cycle of a CPU write
  ti_mem_pkg::bank_t      cart_bank;
  ti_mem_pkg::win_reg_t   win_reg;
  ti_mem_pkg::sams_page_t sams_page;
  ti_mem_pkg::cpu_data_t  sams_rdata;

  assign mem_wdata_o = cpu_data_i;  // Full-word writes only

  cs_decode u_cs_decode (
    .cpu_addr_i      (cpu_addr_i),
    .cpu_wr_i        (cpu_wr_i),
    .sams_en_i       (sams_en),
    .xram_cs_o       (xram_cs),
    .cart_cs_o       (cart_cs),
    .window_cs_o     (window_cs),
    .winreg_cs_o     (winreg_cs),
    .sams_reg_cs_o   (sams_reg_cs),
    .sams_area_cs_o  (sams_area_cs),
    .sams_cru_cs_o   (sams_cru_cs)
  );

  bank_regs u_bank_regs (
    .clk          (clk),
    .cpu_reset    (cpu_reset),
    .cpu_addr_i   (cpu_addr_i),
    .cpu_data_i   (cpu_data_i),
    .wr_start_i   (wr_start),
    .cart_cs_i    (cart_cs),
    .winreg_cs_i  (winreg_cs),
    .cart_bank_o  (cart_bank),
    .win_reg_o    (win_reg)
  );

  sams_pager u_sams_pager (
    .clk            (clk),
    .cpu_reset      (cpu_reset),
    .cpu_addr_i     (cpu_addr_i),
    .cpu_data_i     (cpu_data_i),
    .wr_start_i     (wr_start),
    .cru_clk_i      (cru_clk_i),
    .cru_bit_i      (cru_bit_i),
    .sams_cru_cs_i  (sams_cru_cs),
    .sams_reg_cs_i  (sams_reg_cs),
    .sams_en_o      (sams_en),
    .page_o         (sams_page),
    .reg_rdata_o    (sams_rdata)
  );

  xaddr_map u_xaddr_map (
    .cpu_addr_i      (cpu_addr_i),
    .cart_cs_i       (cart_cs),
    .window_cs_i     (window_cs),
    .sams_area_cs_i  (sams_area_cs),
    .winreg_cs_i     (winreg_cs),
    .sams_reg_cs_i   (sams_reg_cs),
    .xram_cs_i       (xram_cs),
    .cart_bank_i     (cart_bank),
    .win_reg_i       (win_reg),
    .sams_page_i     (sams_page),
    .sams_rdata_i    (sams_rdata),
    .mem_rdata_i     (mem_rdata_i),
    .mem_addr_o      (mem_addr_o),
    .cpu_data_o      (cpu_data_o)
  );

  xmem_seq u_xmem_seq (
    .clk          (clk),
    .cpu_reset    (cpu_reset),
    .cpu_rd_i     (cpu_rd_i),
    .cpu_wr_i     (cpu_wr_i),
    .xram_cs_i    (xram_cs),
    .mem_ack_i    (mem_ack_i),
    .mem_rd_rq_o  (mem_rd_rq_o),
    .mem_wr_rq_o  (mem_wr_rq_o),
    .wr_start_o   (wr_start),
    .cpu_ready_o  (cpu_ready_o)
  );

endmodule

`default_nettype wire

// File: dv/tb_ti_memsys.sv
// Testbench for the CPU-side memory system.
// Plays the CPU and the external memory, runs a directed start and then
// random accesses from an LCG, and checks each one against a reference model.

`timescale 1ns/1ps
`default_nettype none

module tb_ti_memsys;

  localparam int RESET_CYCLES = 8;
  localparam int NUM_DIRECTED = 13;
  localparam int NUM_TXN      = 400;
  localparam int TIMEOUT      = (NUM_DIRECTED + NUM_TXN) * 12 + RESET_CYCLES;

  logic        clk;
  logic        cpu_reset;
  logic [15:0] cpu_addr, cpu_data;
  logic        cpu_rd, cpu_wr, cru_clk, cru_bit;
  logic [15:0] mem_rdata;
  logic        mem_ack;
  wire  [15:0] cpu_rdata;
  wire         cpu_ready;
  wire  [22:0] mem_addr;
  wire  [15:0] mem_wdata;
  wire         mem_rd_rq, mem_wr_rq;

  // Reference model state
  logic [7:0]  ref_bank;
  logic [15:0] ref_win;
  logic        ref_sams_en, ref_map_en;
  logic [7:0]  ref_pages [16];
  logic [15:0] ref_mem [logic [22:0]];    // Expected memory contents
  logic [15:0] mem_model [logic [22:0]];  // What the memory model holds
  logic [31:0] rng_state;
  int          cycle_cnt;

  ti_memsys dut_i (
    .clk          (clk),
    .cpu_reset    (cpu_reset),
    .cpu_addr_i   (cpu_addr),
    .cpu_data_i   (cpu_data),
    .cpu_rd_i     (cpu_rd),
    .cpu_wr_i     (cpu_wr),
    .cru_clk_i    (cru_clk),
    .cru_bit_i    (cru_bit),
    .cpu_data_o   (cpu_rdata),
    .cpu_ready_o  (cpu_ready),
    .mem_rdata_i  (mem_rdata),
    .mem_ack_i    (mem_ack),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_rd_rq_o  (mem_rd_rq),
    .mem_wr_rq_o  (mem_wr_rq)
  );

  always #50 clk = ~clk;  // 100 ns period

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state >> 8;  // Low LCG bits are weak
  endfunction

  // Content of a never written word depends on every address bit
  function automatic logic [15:0] fill_word(input logic [22:0] a);
    return a[15:0] ^ {a[22:16], a[22:14]};
  endfunction

  function automatic logic [22:0] map_xaddr(input logic [15:0] a);
    logic [7:0] page;
    page = ref_map_en ? ref_pages[a[15:12]] : {4'h0, a[15:12]};
    if (a[15:13] == 3'b011) return {3'b001, ref_bank, a[12:1]};  // Cartridge bank
    if (a[15:8] == 8'h85) return {ref_win, a[7:1]};              // Window
    if (a[15:13] == 3'b001 || a[15:13] == 3'b101 || a[15:14] == 2'b11)
      return {4'b0001, page, a[11:1]};                           // SAMS area
    return {8'h00, a[15:1]};
  endfunction

  // Does this access reach the external memory
  function automatic logic reaches_memory(input logic [15:0] a, input logic wr);
    if (a[15:13] == 3'b000 || a[15:13] == 3'b011) return !wr;  // Read only
    if (a[15:13] == 3'b001 || a[15:13] == 3'b101 || a[15:14] == 2'b11) return 1'b1;
    if (a[15:10] == 6'b100000 || a[15:8] == 8'h85) return 1'b1;
    return 1'b0;
  endfunction

  function automatic logic [15:0] predict_rdata(input logic [15:0] a, input logic [22:0] x);
    if (a[15:8] == 8'h86) return ref_win;
    if (a[15:13] == 3'b010 && ref_sams_en) return {ref_pages[a[4:1]], ref_pages[a[4:1]]};
    if (!reaches_memory(a, 1'b0)) return 16'h0000;  // Unmapped
    return ref_mem.exists(x) ? ref_mem[x] : fill_word(x);
  endfunction

  // Offsets kept small so that reads often hit earlier writes
  function automatic logic [15:0] pick_addr(input int region, input logic [31:0] r);
    logic [15:0] off;
    logic [2:0]  hi;
    off = r[15:0] & 16'h103E;  // Two 4K blocks of 32 words each
    hi  = 3'd5 + 3'(r[20:16] % 3);
    case (region)
      0:       return {3'b000, off[12:0]};          // ROM
      1:       return {3'b001, off[12:0]};          // Low 8K RAM
      2:       return {3'b010, off[12:0]};          // SAMS registers
      3:       return {3'b011, r[12:1], 1'b0};      // Cartridge in any bank
      4:       return {6'b100000, off[9:0]};        // Scratchpad
      5:       return {8'h85, off[7:0]};            // Window
      6:       return {8'h86, r[7:1], 1'b0};        // Window register
      7:       return {hi, off[12:0]};              // A000..FFFF
      default: return {4'h9, off[11:0]};            // Nothing there
    endcase
  endfunction

  task automatic stop_on_error();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // ----------------------------------------
  // CPU and memory drivers
  // ----------------------------------------
  task automatic cru_write(input logic [15:0] addr, input logic bit_val);
    @(posedge clk);
    cpu_addr <= addr;
    cru_bit  <= bit_val;
    cru_clk  <= 1'b1;
    @(posedge clk);
    cru_clk <= 1'b0;
    @(posedge clk);
    if (addr[7:1] == 7'd0) ref_sams_en = bit_val;       // 1E00
    else if (addr[7:1] == 7'd1) ref_map_en = bit_val;   // 1E02
  endtask

  // One full strobe handshake that also answers as the memory
  task automatic cpu_access(input logic [15:0] addr, input logic wr, input logic [15:0] wdata);
    logic [22:0] exp_xaddr, req_addr;
    logic [15:0] exp_rdata;
    logic        exp_mem, ack_seen, ready_seen;
    int          n_req, ack_cnt, lat, cyc, req_cyc;
    exp_xaddr  = map_xaddr(addr);
    exp_mem    = reaches_memory(addr, wr);
    exp_rdata  = predict_rdata(addr, exp_xaddr);
    req_addr   = '0;
    ack_seen   = 1'b0;
    ready_seen = 1'b0;
    n_req      = 0;
    ack_cnt    = 0;
    lat        = 0;
    cyc        = 0;
    req_cyc    = 0;
    @(posedge clk);
    cpu_addr <= addr;
    cpu_data <= wdata;
    cpu_rd   <= !wr;
    cpu_wr   <= wr;
    while (!ready_seen) begin
      @(negedge clk);
      cyc++;
      if (mem_rd_rq || mem_wr_rq) begin
        n_req++;
        req_cyc  = cyc;
        req_addr = mem_addr;
        check_value("mem_addr_o", mem_addr, exp_xaddr);
        check_value("mem_rd_rq_o", mem_rd_rq, !wr);
        check_value("mem_wr_rq_o", mem_wr_rq, wr);
        if (wr) check_value("mem_wdata_o", mem_wdata, wdata);
        lat     = 1 + int'(next_rand() % 4);  // Ack latency 1..4
        ack_cnt = lat;
        if (wr) mem_model[mem_addr] = mem_wdata;
      end
      if (mem_ack) ack_seen = 1'b1;
      if (cpu_ready) begin
        ready_seen = 1'b1;
        if (exp_mem && !ack_seen) begin
          $display("ERROR at %0t ns: cpu_ready_o rose before mem_ack_i", $time);
          stop_on_error();
        end
        check_value("ready cycle", cyc, exp_mem ? req_cyc + lat : 2);
        if (!wr) check_value("cpu_data_o", cpu_rdata, exp_rdata);
      end
      @(posedge clk);
      mem_ack <= 1'b0;  // Single-cycle ack
      if (ack_cnt > 0) begin
        ack_cnt--;
        if (ack_cnt == 0) begin
          mem_ack   <= 1'b1;
          mem_rdata <= mem_model.exists(req_addr) ? mem_model[req_addr] : fill_word(req_addr);
        end
      end
      if (ready_seen) begin
        cpu_rd <= 1'b0;
        cpu_wr <= 1'b0;
      end
    end
    @(negedge clk);
    check_value("cpu_ready_o held", cpu_ready, 1'b1);  // Falls one cycle after the drop
    if (mem_rd_rq || mem_wr_rq) n_req++;
    @(negedge clk);
    check_value("cpu_ready_o released", cpu_ready, 1'b0);
    if (mem_rd_rq || mem_wr_rq) n_req++;
    check_value("request count", n_req, exp_mem);
    if (exp_mem) check_value("request cycle", req_cyc, 1);
    // Reference update after the access completes
    if (wr) begin
      if (addr[15:13] == 3'b011) ref_bank = addr[8:1];
      if (addr[15:8] == 8'h86) ref_win = wdata;
      if (addr[15:13] == 3'b010 && ref_sams_en) ref_pages[addr[4:1]] = wdata[15:8];
      if (exp_mem) ref_mem[exp_xaddr] = wdata;
    end
  endtask

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("ERROR: timeout after %0d cycles, an access never completed", cycle_cnt);
      stop_on_error();
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic [31:0] r, a_rand, d_rand;
    int          region;
    clk         = 1'b0;
    cpu_reset   = 1'b1;
    cpu_addr    = '0;
    cpu_data    = '0;
    cpu_rd      = 1'b0;
    cpu_wr      = 1'b0;
    cru_clk     = 1'b0;
    cru_bit     = 1'b0;
    mem_rdata   = '0;
    mem_ack     = 1'b0;
    cycle_cnt   = 0;
    rng_state   = 32'hbb5c;
    ref_bank    = '0;
    ref_win     = '0;
    ref_sams_en = 1'b0;
    ref_map_en  = 1'b0;
    for (int i = 0; i < 16; i++) begin
      ref_pages[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    cpu_reset <= 1'b0;
    @(negedge clk);
    check_value("cpu_ready_o after reset", cpu_ready, 1'b0);
    check_value("mem_rd_rq_o after reset", mem_rd_rq, 1'b0);
    check_value("mem_wr_rq_o after reset", mem_wr_rq, 1'b0);

    // Directed start with one pass through each feature
    cpu_access(16'h2010, 1'b1, 16'h1234);   // RAM write
    cpu_access(16'h2010, 1'b0, 16'h0000);   // and read back
    cpu_access(16'h1000, 1'b1, 16'hdead);   // Protected ROM write
    cpu_access(16'h6046, 1'b1, 16'h0000);   // Bank 0x23
    cpu_access(16'h6100, 1'b0, 16'h0000);
    cpu_access(16'h8600, 1'b1, 16'hc0de);   // Window register
    cpu_access(16'h8600, 1'b0, 16'h0000);
    cpu_access(16'h8542, 1'b1, 16'h5a5a);   // Through the window
    cru_write(16'h1E00, 1'b1);              // SAMS registers visible
    cpu_access(16'h4014, 1'b1, 16'h3700);   // Page reg 10 (A000 block)
    cpu_access(16'h4014, 1'b0, 16'h0000);
    cru_write(16'h1E02, 1'b1);              // Mapping on
    cpu_access(16'hA002, 1'b1, 16'h7777);

    for (int n = 0; n < NUM_TXN; n++) begin
      r      = next_rand();
      region = int'(r % 10);
      a_rand = next_rand();
      d_rand = next_rand();
      if (region == 9) begin
        cru_write(r[8] ? 16'h1E02 : 16'h1E00, r[9]);  // Toggle a SAMS bit
      end else begin
        cpu_access(pick_addr(region, a_rand), r[12], d_rand[15:0]);
      end
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: ti_memsys.f
design/ti_mem_pkg.sv
design/cs_decode.sv
design/bank_regs.sv
design/sams_pager.sv
design/xaddr_map.sv
design/xmem_seq.sv
design/ti_memsys.sv
dv/tb_ti_memsys.sv
